//--- src.f
common/icache_pkg.sv
icache/icache_tag_array.sv
icache/icache_data_array.sv
icache/icache_word_select.sv
hdl/icache_top.sv
testbench/icache_assertions.sv
testbench/icache_tb.sv

//--- Makefile
# Verilator build and run of the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

# the binary exits nonzero when the testbench hits $fatal
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- testbench/icache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module icache_tb
	import icache_pkg::*;
();

	localparam int ADDR_W = 64;
	localparam int INDEX_W = 6;
	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 8;
	localparam int RANDOM_CYCLES = 400;
	// directed tests together stay well below this
	localparam int DIRECTED_CYCLES = 60;
	localparam int MAX_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 20;
	localparam logic [31:0] SEED = 32'ha0ae1397;
	// tags used by the tests, high enough to reach the upper address word
	localparam logic [ADDR_W-1:0] TAG_BASE = 64'h0003_7c10_0000;

	// expected hit per request
	localparam int EXP_MISS = 0;
	localparam int EXP_HIT = 1;
	localparam int EXP_ANY = 2;

	logic              clk;
	logic              rst;
	logic [ADDR_W-1:0] addr;
	logic              valid;
	logic              flush;
	logic              ready_ifid;
	logic [WORD_W-1:0] inst;
	logic              ready;
	logic              hit;
	logic [ADDR_W-1:0] mem_addr;
	line_t             mem_line;

	string test_name;
	int    exp_hit;
	int    cycle_count = 0;

	// request seen in the previous cycle
	logic [ADDR_W-1:0] prev_addr;
	logic              prev_valid;
	logic              prev_flush;
	int                prev_exp_hit;
	string             prev_name;

	icache_top #(
		.ADDR_W(ADDR_W),
		.INDEX_W(INDEX_W)
	) icache_top_i (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.valid(valid),
		.flush(flush),
		.ready_ifid(ready_ifid),
		.inst(inst),
		.ready(ready),
		.hit(hit),
		.mem_addr(mem_addr),
		.mem_line(mem_line)
	);

	// way_hit reaches the word selector straight from the tag array
	bind icache_word_select icache_assertions icache_assertions_i (
		.clk(clk),
		.rst(rst),
		.valid(valid),
		.flush(flush),
		.way_hit(way_hit),
		.ready(ready),
		.hit(hit)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// memory content, each word is a scramble of its own byte address
	function automatic logic [WORD_W-1:0] mem_word(input logic [ADDR_W-1:0] word_addr);
		logic [31:0] lo;
		logic [31:0] hi;
		lo = word_addr[31:0];
		hi = word_addr[ADDR_W-1:32];
		return (lo * 32'h9e3779b1) ^ {hi[15:0], hi[31:16]} ^ 32'h6d2b79f5;
	endfunction

	// reference: the word the fetch stage should see for an address
	function automatic logic [WORD_W-1:0] expected_inst(input logic [ADDR_W-1:0] a);
		return mem_word({a[ADDR_W-1:2], 2'b00});
	endfunction

	// full line around an address, word 0 in the low bits
	function automatic line_t line_at(input logic [ADDR_W-1:0] a);
		line_t             line;
		logic [ADDR_W-1:0] base;
		base = {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
		for (int i = 0; i < WORDS_PER_LINE; i++) begin
			line[i*WORD_W +: WORD_W] = mem_word(base + ADDR_W'(i * 4));
		end
		return line;
	endfunction

	// backing memory answers in the same cycle
	assign mem_line = line_at(mem_addr);

	function automatic logic [ADDR_W-1:0] make_addr(input logic [ADDR_W-1:0] tag,
			input int index, input int word);
		return (tag << (INDEX_W + OFFSET_W)) | (ADDR_W'(index) << OFFSET_W) | ADDR_W'(word * 4);
	endfunction

	task automatic check_value(input string name, input string what,
			input logic [63:0] expected, input logic [63:0] actual);
		if (expected !== actual) begin
			$display("Fail %s %s: expected %h, actual %h", name, what, expected, actual);
			$display("Regression failed");
			$fatal(1, "mismatch in test %s", name);
		end
	endtask

	// compare at the falling edge where all outputs are settled
	always @(negedge clk) begin
		if (!rst) begin
			// memory port carries the fetch address of this cycle
			check_value(test_name, "mem_addr", 64'(addr), 64'(mem_addr));
			check_value(prev_name, "ready", 64'(prev_valid && !prev_flush), 64'(ready));
			if (ready) begin
				check_value(prev_name, "inst", 64'(expected_inst(prev_addr)), 64'(inst));
				if (prev_exp_hit != EXP_ANY) begin
					check_value(prev_name, "hit", 64'(prev_exp_hit), 64'(hit));
				end
			end else begin
				check_value(prev_name, "hit", 64'(0), 64'(hit));
			end
		end
		prev_addr = addr;
		prev_valid = valid && !rst;
		prev_flush = flush;
		prev_exp_hit = exp_hit;
		prev_name = test_name;
	end

	// run limit from reset, directed and random lengths
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: run did not end within %0d cycles", MAX_CYCLES);
			$display("Regression failed");
			$fatal(1, "timeout");
		end
	end

	// one request cycle, inputs change right after the rising edge
	task automatic drive_cycle(input logic [ADDR_W-1:0] a, input logic v, input logic f,
			input logic r, input int eh);
		@(posedge clk);
		addr <= a;
		valid <= v;
		flush <= f;
		ready_ifid <= r;
		exp_hit <= eh;
	endtask

	task automatic fetch(input logic [ADDR_W-1:0] a, input int eh);
		drive_cycle(a, 1'b1, 1'b0, 1'b1, eh);
	endtask

	task automatic idle();
		drive_cycle(addr, 1'b0, 1'b0, 1'b1, EXP_ANY);
	endtask

	// every line is new after reset
	task automatic cold_miss_test();
		test_name = "cold_miss";
		for (int i = 0; i < 4; i++) begin
			fetch(make_addr(TAG_BASE + ADDR_W'(i), i, i), EXP_MISS);
		end
		idle();
	endtask

	// miss fills the line, then every word of it hits
	task automatic rehit_test();
		test_name = "rehit";
		fetch(make_addr(TAG_BASE, 8, 1), EXP_MISS);
		fetch(make_addr(TAG_BASE, 8, 1), EXP_HIT);
		fetch(make_addr(TAG_BASE, 8, 0), EXP_HIT);
		fetch(make_addr(TAG_BASE, 8, 2), EXP_HIT);
		fetch(make_addr(TAG_BASE, 8, 3), EXP_HIT);
		idle();
	endtask

	// back to back misses in one set land in distinct ways
	task automatic four_way_test();
		test_name = "four_ways";
		for (int w = 0; w < WAYS; w++) begin
			fetch(make_addr(TAG_BASE + ADDR_W'(16 + w), 12, w), EXP_MISS);
		end
		for (int w = 0; w < WAYS; w++) begin
			fetch(make_addr(TAG_BASE + ADDR_W'(16 + w), 12, (w + 1) % 4), EXP_HIT);
		end
		idle();
	endtask

	// decode not ready, line is returned but not kept
	task automatic back_pressure_test();
		test_name = "back_pressure";
		drive_cycle(make_addr(TAG_BASE, 20, 2), 1'b1, 1'b0, 1'b0, EXP_MISS);
		fetch(make_addr(TAG_BASE, 20, 2), EXP_MISS);
		fetch(make_addr(TAG_BASE, 20, 3), EXP_HIT);
		idle();
	endtask

	// flushed access gives no output but still refills
	task automatic flush_test();
		test_name = "flush";
		drive_cycle(make_addr(TAG_BASE, 24, 0), 1'b1, 1'b1, 1'b1, EXP_ANY);
		fetch(make_addr(TAG_BASE, 24, 1), EXP_HIT);
		fetch(make_addr(TAG_BASE, 25, 2), EXP_MISS);
		idle();
	endtask

	// six tags over two sets force evictions
	task automatic random_test();
		logic [ADDR_W-1:0] a;
		logic              v;
		logic              f;
		logic              r;
		test_name = "random_mix";
		for (int n = 0; n < RANDOM_CYCLES; n++) begin
			a = make_addr(TAG_BASE + ADDR_W'(32 + $urandom_range(0, 5)),
				40 + $urandom_range(0, 1), $urandom_range(0, 3));
			v = ($urandom_range(0, 3) != 0);
			f = ($urandom_range(0, 15) == 0);
			r = ($urandom_range(0, 7) != 0);
			drive_cycle(a, v, f, r, EXP_ANY);
		end
		idle();
	endtask

	initial begin
		int seed_ret;
		seed_ret = $urandom(SEED);
		test_name = "reset";
		rst <= 1'b1;
		addr <= '0;
		valid <= 1'b0;
		flush <= 1'b0;
		ready_ifid <= 1'b1;
		exp_hit <= EXP_ANY;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		cold_miss_test();
		rehit_test();
		four_way_test();
		back_pressure_test();
		flush_test();
		random_test();
		// let the last requests reach the compare process
		idle();
		repeat (2) @(negedge clk);
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/icache_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module icache_assertions
	import icache_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic valid,
	input wire logic flush,
	input wire way_t way_hit,
	input wire logic ready,
	input wire logic hit
);

	// a refill only happens on a miss, so a tag sits in one way only
	way_hit_onehot: assert property (
		@(posedge clk) disable iff (rst) $onehot0(way_hit)
	) else $error("more than one way matched, way_hit %b", way_hit);

	// outputs come out of reset idle
	idle_after_reset: assert property (
		@(posedge clk) rst |=> (!ready && !hit)
	) else $error("ready or hit high right after reset");

	// nothing returned for an idle or flushed cycle
	no_ready_after_idle: assert property (
		@(posedge clk) disable iff (rst) (!valid || flush) |=> !ready
	) else $error("ready high after a cycle without a live request");

	// hit is only meaningful with ready
	hit_needs_ready: assert property (
		@(posedge clk) disable iff (rst) hit |-> ready
	) else $error("hit high while ready is low");

endmodule

`default_nettype wire

//--- hdl/icache_top.sv
`timescale 1ns/10ps
`default_nettype none

module icache_top
	import icache_pkg::*;
#(
	parameter int ADDR_W = 64,
	parameter int INDEX_W = 6
) (
	input  wire logic              clk,
	input  wire logic              rst,
	// fetch side
	input  wire logic [ADDR_W-1:0] addr,
	input  wire logic              valid,
	input  wire logic              flush,
	input  wire logic              ready_ifid,
	output logic [WORD_W-1:0]      inst,
	output logic                   ready,
	output logic                   hit,
	// backing memory, answers in the same cycle
	output logic [ADDR_W-1:0]      mem_addr,
	input  wire line_t             mem_line
);

	way_t             way_hit;
	way_t             refill_way;
	line_t [WAYS-1:0] way_lines;

	// memory sees the fetch address directly
	assign mem_addr = addr;

	// hit detection, victim choice and tag refill
	icache_tag_array #(
		.ADDR_W(ADDR_W),
		.INDEX_W(INDEX_W)
	) icache_tag_array_i (
		.clk(clk),
		.rst(rst),
		.addr(addr),
		.valid(valid),
		.flush(flush),
		.ready_ifid(ready_ifid),
		.way_hit(way_hit),
		.refill_way(refill_way)
	);

	// line storage, looked up in parallel with the tags
	icache_data_array #(
		.INDEX_W(INDEX_W)
	) icache_data_array_i (
		.clk(clk),
		.index(addr[OFFSET_W +: INDEX_W]),
		.refill_way(refill_way),
		.mem_line(mem_line),
		.way_lines(way_lines)
	);

	// output stage
	icache_word_select icache_word_select_i (
		.clk(clk),
		.rst(rst),
		.offset(addr[OFFSET_W-1:0]),
		.valid(valid),
		.flush(flush),
		.way_hit(way_hit),
		.way_lines(way_lines),
		.mem_line(mem_line),
		.inst(inst),
		.ready(ready),
		.hit(hit)
	);

endmodule

`default_nettype wire

//--- icache/icache_word_select.sv
`timescale 1ns/10ps
`default_nettype none

module icache_word_select
	import icache_pkg::*;
(
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire logic [OFFSET_W-1:0] offset,
	input  wire logic                valid,
	input  wire logic                flush,
	input  wire way_t                way_hit,
	input  wire line_t [WAYS-1:0]    way_lines,
	input  wire line_t               mem_line,
	output logic [WORD_W-1:0]        inst,
	output logic                     ready,
	output logic                     hit
);

	// state of the access in flight
	way_t                  way_hit_q;
	line_t                 mem_line_q;
	logic [WORD_SEL_W-1:0] word_q;

	// line chosen from the ways or from memory
	line_t sel_line;

	// control registers, flush drops the access in flight
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			way_hit_q <= WAY_NONE;
			ready     <= 1'b0;
			hit       <= 1'b0;
		end else begin
			way_hit_q <= way_hit;
			ready     <= valid;
			// a match on an idle cycle is not a hit
			hit       <= valid && (way_hit != WAY_NONE);
		end
	end

	// fill line and word index, cleared together with the control
	always_ff @(posedge clk) begin
		if (flush) begin
			mem_line_q <= '0;
			word_q     <= '0;
		end else begin
			mem_line_q <= mem_line;
			word_q     <= offset[OFFSET_W-1 -: WORD_SEL_W];
		end
	end

	// one-hot mux over the ways, memory line on a miss
	always_comb begin
		sel_line = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (way_hit_q[w]) begin
				sel_line = sel_line | way_lines[w];
			end
		end
		if (way_hit_q == WAY_NONE) begin
			sel_line = mem_line_q;
		end
	end

	// word within the line
	assign inst = sel_line[word_q*WORD_W +: WORD_W];

endmodule

`default_nettype wire

//--- icache/icache_data_array.sv
`timescale 1ns/10ps
`default_nettype none

module icache_data_array
	import icache_pkg::*;
#(
	parameter int INDEX_W = 6
) (
	input  wire logic               clk,
	input  wire logic [INDEX_W-1:0] index,
	input  wire way_t               refill_way,
	input  wire line_t              mem_line,
	output line_t [WAYS-1:0]        way_lines
);

	localparam int SETS = 1 << INDEX_W;

	// one single-port line memory per way
	// read every cycle, the way in refill_way writes mem_line
	// on a write the read returns the old line, the word
	// selector then takes the registered memory line anyway
	genvar w;
	generate
		for (w = 0; w < WAYS; w++) begin : g_way
			line_t mem [SETS];

			always_ff @(posedge clk) begin
				if (refill_way[w]) begin
					mem[index] <= mem_line;
				end
				// registered read, one cycle latency
				way_lines[w] <= mem[index];
			end
		end
	endgenerate

endmodule

`default_nettype wire

//--- icache/icache_tag_array.sv
`timescale 1ns/10ps
`default_nettype none

module icache_tag_array
	import icache_pkg::*;
#(
	parameter int ADDR_W = 64,
	parameter int INDEX_W = 6
) (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic [ADDR_W-1:0] addr,
	input  wire logic              valid,
	input  wire logic              flush,
	input  wire logic              ready_ifid,
	output way_t                   way_hit,
	output way_t                   refill_way
);

	// tag is whatever is left above index and offset
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
	localparam int SETS = 1 << INDEX_W;

	// address fields
	logic [INDEX_W-1:0] index;
	logic [TAG_W-1:0]   tag;

	// per way storage, valid bit and tag for every set
	logic [SETS-1:0]  valid_bits [WAYS];
	logic [TAG_W-1:0] tags [WAYS][SETS];

	// rotating one-hot victim pointer
	way_t victim;

	// a miss that the decode stage can take
	logic refill;

	assign index = addr[OFFSET_W +: INDEX_W];
	assign tag   = addr[ADDR_W-1 -: TAG_W];

	// compare all ways in parallel
	// at most one way can match since a refill only happens on a miss
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			way_hit[w] = valid_bits[w][index] && (tags[w][index] == tag);
		end
	end

	// no way matched and decode is ready, so the line gets written
	assign refill = valid && (way_hit == WAY_NONE) && ready_ifid;

	// victim way is handed to the data array only on a refill
	assign refill_way = refill ? victim : WAY_NONE;

	// victim pointer moves on every cycle except flush cycles
	always_ff @(posedge clk) begin
		if (rst) begin
			victim <= VICTIM_INIT;
		end else if (!flush) begin
			victim <= {victim[WAYS-2:0], victim[WAYS-1]};
		end
	end

	// valid bits start cleared, set when the way gets refilled
	// flushed accesses still refill, flush only drops the output
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < WAYS; w++) begin
				valid_bits[w] <= '0;
			end
		end else begin
			for (int w = 0; w < WAYS; w++) begin
				if (refill_way[w]) begin
					valid_bits[w][index] <= 1'b1;
				end
			end
		end
	end

	// tag write goes with the valid bit of the same way
	always_ff @(posedge clk) begin
		for (int w = 0; w < WAYS; w++) begin
			if (refill_way[w]) begin
				tags[w][index] <= tag;
			end
		end
	end

endmodule

`default_nettype wire

//--- common/icache_pkg.sv
`default_nettype none

package icache_pkg;

	// associativity of the cache
	localparam int WAYS = 4;

	// byte offset inside a line, 16 bytes per line
	localparam int OFFSET_W = 4;

	// line and instruction geometry
	localparam int LINE_W = 128;
	localparam int WORD_W = 32;
	localparam int WORDS_PER_LINE = LINE_W / WORD_W;

	// bits of the offset that pick a word within the line
	localparam int WORD_SEL_W = $clog2(WORDS_PER_LINE);

	// one bit per way, used one-hot for hits, enables and the victim
	typedef logic [WAYS-1:0] way_t;

	// a whole cache line as it comes from memory
	typedef logic [LINE_W-1:0] line_t;

	// no way selected
	localparam way_t WAY_NONE = '0;

	// one-hot encodings of the single ways
	localparam way_t WAY0 = way_t'(1) << 0;
	localparam way_t WAY1 = way_t'(1) << 1;
	localparam way_t WAY2 = way_t'(1) << 2;
	localparam way_t WAY3 = way_t'(1) << 3;

	// first victim after reset
	localparam way_t VICTIM_INIT = WAY0;

endpackage

`default_nettype wire
